/* dv/resdmac_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module resdmac_checker (
    input wire sclk_i,
    input wire rst_n_i,
    input wire br_i,
    input wire own_i,
    input wire as_n_i,
    input wire dack_n_i,
    input wire ior_n_i,
    input wire iow_n_i,
    input wire full_i
);

    // Address strobe only while the bus is held
    a_as_owned: assert property (@(posedge sclk_i) disable iff (!rst_n_i)
        !as_n_i |-> own_i)
        else $error("as_n low without bus ownership");

    // A read strobe starts only when the FIFO had room
    a_no_dack_full: assert property (@(posedge sclk_i) disable iff (!rst_n_i)
        ($fell(ior_n_i) && !dack_n_i) |-> !$past(full_i))
        else $error("read strobe started with the FIFO full");

    a_strobe_excl: assert property (@(posedge sclk_i) disable iff (!rst_n_i)
        !(!ior_n_i && !iow_n_i))
        else $error("ior_n and iow_n low together");

    a_br_reset: assert property (@(posedge sclk_i)
        $rose(rst_n_i) |-> !br_i)
        else $error("br high right after reset");

endmodule

bind resdmac resdmac_checker u_checker (
    .sclk_i   (sclk_i),
    .rst_n_i  (rst_n_i),
    .br_i     (br_o),
    .own_i    (own_o),
    .as_n_i   (as_n_o),
    .dack_n_i (dack_n_o),
    .ior_n_i  (ior_n_o),
    .iow_n_i  (iow_n_o),
    .full_i   (stat.full)
);

`default_nettype wire

/* dv/resdmac_patterns.hex */
// Each phase: tag, count, values offered, then values expected
// Halfwords sit zero extended in 32-bit words
// Phase 2: halfwords from the peripheral, expected memory writes
00000002 00000004
0000a1b2 0000c3d4 0000e5f6 00000718
a1b2c3d4 e5f60718
// Phase 3: longwords served on reads, expected halfwords on pd_o
00000003 00000002
11223344 55667788
00001122 00003344 00005566 00007788
// Phase 4: odd halfword count, flush pads the last longword
00000004 00000003
0000dead 0000beef 00000bad
deadbeef 0bad0000
// Phase 5: grant withheld while DREQ stays low
00000005 0000000c
00001001 00002002 00003003 00004004 00005005 00006006
00007007 00008008 00009009 0000a00a 0000b00b 0000c00c
10012002 30034004 50056006 70078008 9009a00a b00bc00c

/* dv/tb_resdmac.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_resdmac;

    localparam int FIFO_DEPTH = 4;
    localparam int TIMEOUT    = 2000;   // Cycles per wait

    logic sclk_i, rst_n_i, reg_sel_i, reg_we_i;
    logic [4:0]  reg_addr_i;
    logic [31:0] reg_wdata_i, reg_rdata_o, data_i, data_o;
    logic br_o, bg_n_i, own_o, as_n_o, ds_n_o, rw_o, berr_n_i;
    logic [1:0]  dsack_n_i;
    logic dreq_n_i, dack_n_o, ior_n_o, iow_n_o, periph_int_i, int_o;
    logic [15:0] pd_i, pd_o;

    logic [31:0] pat [0:63];
    logic [15:0] offer [0:15];
    logic [31:0] mem_rd [0:15];
    logic [31:0] mem_wr [0:15];
    logic [15:0] rx_half [0:15];
    int pidx, offer_cnt, offer_idx, rd_cnt, rd_idx, wr_cnt, rx_cnt, rx_want;
    int pulses, gnt_wait, ack_wait, err_cnt, seed;
    logic p_dir, hold_grant, ior_prev, iow_prev;
    logic [31:0] rdata;

    resdmac #(.FIFO_DEPTH(FIFO_DEPTH), .STROBE_CYCLES(2)) DUT (.*);

    initial begin
        sclk_i = 1'b0;
        forever #5 sclk_i = ~sclk_i;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic bit event_seen(input int kind, input int n);
        case (kind)
            0: return wr_cnt >= n;
            1: return rx_cnt >= n;
            2: return offer_idx >= n;
            3: return pulses >= n;
            4: return int_o;
            default: return !own_o && !br_o;
        endcase
    endfunction

    task automatic wait_until(input int kind, input int n, input string what);
        int t;
        t = 0;
        while (!event_seen(kind, n)) begin
            @(posedge sclk_i);
            #1;
            t++;
            if (t > TIMEOUT) begin
                $display("Timeout at %0t: %s never happened", $time, what);
                $display("Test FAILED");
                $fatal(1, "timeout");
            end
        end
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] wdata);
        @(posedge sclk_i);
        #1;
        {reg_sel_i, reg_we_i, reg_addr_i, reg_wdata_i} = {2'b11, addr, wdata};
        @(posedge sclk_i);
        #1;
        reg_sel_i = 1'b0;
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] rd);
        @(posedge sclk_i);
        #1;
        {reg_sel_i, reg_we_i, reg_addr_i} = {2'b10, addr};
        @(posedge sclk_i);
        #1;
        reg_sel_i = 1'b0;
        rd = reg_rdata_o;
    endtask

    task automatic read_header(input int tag, output int n);
        check_value(pat[pidx], tag, "pattern phase tag");
        n = pat[pidx+1];
        pidx += 2;
    endtask

    task automatic load_offer(input int tag);
        read_header(tag, offer_cnt);
        for (int i = 0; i < offer_cnt; i++)
            offer[i] = pat[pidx+i][15:0];
        pidx += offer_cnt;
        {offer_idx, wr_cnt, pulses} = '0;
    endtask

    task automatic compare_writes(input int n);
        for (int i = 0; i < n; i++)
            check_value(mem_wr[i], pat[pidx+i], "memory write");
        pidx += n;
    endtask

    // Bus arbiter and host memory
    always @(posedge sclk_i) begin
        #1;
        check_value(32'(ds_n_o), 32'(as_n_o), "ds_n_o together with as_n_o");
        if (!br_o)
            gnt_wait = {$random(seed)} % 6;
        else if (!hold_grant && bg_n_i) begin
            if (gnt_wait == 0) bg_n_i = 1'b0;
            else gnt_wait--;
        end
        if (own_o) bg_n_i = 1'b1;
        if (as_n_o) begin
            dsack_n_i = 2'b11;
            ack_wait  = {$random(seed)} % 6;
        end else if (dsack_n_i == 2'b11) begin
            if (ack_wait == 0) begin
                dsack_n_i = 2'b00;
                if (rw_o) begin
                    data_i = (rd_idx < rd_cnt) ? mem_rd[rd_idx] : '0;
                    rd_idx++;
                end else if (wr_cnt < 16) begin
                    mem_wr[wr_cnt] = data_o;
                    wr_cnt++;
                end
            end else
                ack_wait--;
        end
    end

    // WD-style peripheral, one halfword per DACK pulse
    always @(posedge sclk_i) begin
        #1;
        // DACK frames every strobe
        check_value(32'(dack_n_o), 32'(ior_n_o & iow_n_o), "dack_n_o with strobe");
        if (!ior_prev && ior_n_o) begin
            offer_idx++;
            pulses++;
        end
        if (!iow_prev && iow_n_o) begin
            if (rx_cnt < 16) rx_half[rx_cnt] = pd_o;
            rx_cnt++;
            pulses++;
        end
        ior_prev = ior_n_o;
        iow_prev = iow_n_o;
        if (!p_dir) begin
            dreq_n_i = !(offer_idx < offer_cnt);
            pd_i     = offer[offer_idx % 16];
        end else
            dreq_n_i = !(rx_cnt < rx_want);
    end

    initial begin
        seed = 33;
        {reg_sel_i, reg_we_i, reg_addr_i, reg_wdata_i, data_i, pd_i} = '0;
        {bg_n_i, berr_n_i, dsack_n_i, dreq_n_i} = '1;
        {periph_int_i, p_dir, hold_grant} = '0;
        {ior_prev, iow_prev} = 2'b11;
        {pidx, offer_cnt, offer_idx, rd_cnt, rd_idx, wr_cnt, rx_cnt, rx_want} = '0;
        {pulses, err_cnt} = '0;
        $readmemh("dv/resdmac_patterns.hex", pat);
        rst_n_i = 1'b0;
        repeat (5) @(posedge sclk_i);
        #1 rst_n_i = 1'b1;

        // Register readback and reset status
        reg_read(sdmac_ctrl_pkg::ADDR_ISTR, rdata);
        check_value(rdata, 32'h08, "status after reset");
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h5);
        reg_read(sdmac_ctrl_pkg::ADDR_CNTR, rdata);
        check_value(rdata, 32'h5, "control readback");
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h0);

        // Peripheral to memory
        load_offer(2);
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h2);
        wait_until(0, offer_cnt / 2, "memory writes of phase 2");
        compare_writes(offer_cnt / 2);
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h0);
        wait_until(5, 0, "bus release after phase 2");

        // Memory to peripheral
        read_header(3, rd_cnt);
        for (int i = 0; i < rd_cnt; i++)
            mem_rd[i] = pat[pidx+i];
        pidx += rd_cnt;
        {rd_idx, rx_cnt} = '0;
        rx_want = 2 * rd_cnt;
        p_dir = 1'b1;
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h6);
        wait_until(1, rx_want, "halfwords on pd_o");
        for (int i = 0; i < rx_want; i++)
            check_value(32'(rx_half[i]), pat[pidx+i], "peripheral halfword");
        pidx += rx_want;
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h0);
        wait_until(5, 0, "bus release after phase 3");
        p_dir = 1'b0;

        // Odd count and flush
        load_offer(4);
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h3);
        wait_until(2, offer_cnt, "all halfwords of phase 4 taken");
        reg_write(sdmac_ctrl_pkg::ADDR_FLUSH, 32'h1);
        wait_until(0, (offer_cnt + 1) / 2, "padded longword write");
        compare_writes((offer_cnt + 1) / 2);
        wait_until(4, 0, "interrupt after flush");
        reg_read(sdmac_ctrl_pkg::ADDR_ISTR, rdata);
        check_value(32'(rdata[4]), 32'h1, "flush-done in status");
        check_value(32'(int_o), 32'h0, "int_o after status read");
        reg_read(sdmac_ctrl_pkg::ADDR_ISTR, rdata);
        check_value(32'(rdata[4]), 32'h0, "flush-done cleared");
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h0);
        wait_until(5, 0, "bus release after phase 4");

        // Grant withheld, FIFO back-pressure
        load_offer(5);
        hold_grant = 1'b1;
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h2);
        wait_until(3, 2 * FIFO_DEPTH, "DACK pulses filling the FIFO");
        repeat (20) @(posedge sclk_i);
        #1;
        check_value(32'(pulses <= 2 * FIFO_DEPTH), 32'h1, "DACK count while stalled");
        hold_grant = 1'b0;
        wait_until(0, offer_cnt / 2, "memory writes of phase 5");
        compare_writes(offer_cnt / 2);
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h0);
        wait_until(5, 0, "bus release after phase 5");

        // Peripheral interrupt gated by int_en
        periph_int_i = 1'b1;
        @(posedge sclk_i);
        #1;
        check_value(32'(int_o), 32'h0, "int_o with int_en clear");
        reg_write(sdmac_ctrl_pkg::ADDR_CNTR, 32'h1);
        check_value(32'(int_o), 32'h1, "int_o with int_en set");
        periph_int_i = 1'b0;
        #1;
        check_value(32'(int_o), 32'h0, "int_o after peripheral interrupt clears");

        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/cpu_sm.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sm (
    input  wire                         sclk_i,
    input  wire                         rst_n_i,
    input  wire sdmac_ctrl_pkg::dma_ctrl_t  ctrl_i,
    input  wire sdmac_ctrl_pkg::fifo_stat_t stat_i,
    input  wire                         bg_n_i,
    input  wire [1:0]                   dsack_n_i,
    input  wire                         berr_n_i,
    input  wire sdmac_bus_pkg::host_data_t  data_i,
    input  wire sdmac_bus_pkg::host_data_t  rd_long_i,
    output logic                        br_o,
    output logic                        own_o,      // BGACK
    output logic                        as_n_o,
    output logic                        ds_n_o,
    output logic                        rw_o,
    output sdmac_bus_pkg::host_data_t   data_o,
    output logic                        push_long_o,
    output logic                        pop_long_o,
    output sdmac_bus_pkg::host_data_t   wr_long_o
);

    sdmac_ctrl_pkg::cpu_state_t state_q;
    logic need_xfer;
    logic dsack_ok;
    logic cycle_end;

    // Direction 0 drains complete longwords, direction 1 fills free slots
    assign need_xfer = ctrl_i.dma_en & (ctrl_i.dir ? ~stat_i.full : stat_i.long_rdy);
    assign dsack_ok  = (dsack_n_i == 2'b00);    // 32-bit port only
    assign cycle_end = dsack_ok | ~berr_n_i;

    always_ff @(posedge sclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= sdmac_ctrl_pkg::CPU_IDLE;
            br_o        <= 1'b0;
            own_o       <= 1'b0;
            as_n_o      <= 1'b1;
            ds_n_o      <= 1'b1;
            rw_o        <= 1'b1;
            push_long_o <= 1'b0;
            pop_long_o  <= 1'b0;
        end else begin
            push_long_o <= 1'b0;
            pop_long_o  <= 1'b0;
            case (state_q)
                sdmac_ctrl_pkg::CPU_IDLE: begin
                    if (need_xfer) begin
                        br_o    <= 1'b1;
                        state_q <= sdmac_ctrl_pkg::CPU_REQ;
                    end
                end
                sdmac_ctrl_pkg::CPU_REQ: begin
                    if (!bg_n_i) begin            // Granted, take the bus
                        br_o    <= 1'b0;
                        own_o   <= 1'b1;
                        state_q <= sdmac_ctrl_pkg::CPU_OWN;
                    end
                end
                sdmac_ctrl_pkg::CPU_OWN: begin
                    as_n_o  <= 1'b0;
                    ds_n_o  <= 1'b0;
                    rw_o    <= ctrl_i.dir;        // Memory read when feeding the peripheral
                    state_q <= sdmac_ctrl_pkg::CPU_CYCLE;
                end
                sdmac_ctrl_pkg::CPU_CYCLE: begin
                    if (cycle_end) begin
                        as_n_o <= 1'b1;
                        ds_n_o <= 1'b1;
                        // Bus error drops the word, it is retried next tenure
                        if (berr_n_i && dsack_ok) begin
                            push_long_o <= rw_o;
                            pop_long_o  <= ~rw_o;
                        end
                        state_q <= sdmac_ctrl_pkg::CPU_RELEASE;
                    end
                end
                sdmac_ctrl_pkg::CPU_RELEASE: begin
                    own_o   <= 1'b0;
                    state_q <= sdmac_ctrl_pkg::CPU_IDLE;
                end
                default: state_q <= sdmac_ctrl_pkg::CPU_IDLE;
            endcase
        end
    end

    always_ff @(posedge sclk_i) begin
        if (state_q == sdmac_ctrl_pkg::CPU_OWN)
            data_o <= rd_long_i;                  // Head word for the write cycle
        if ((state_q == sdmac_ctrl_pkg::CPU_CYCLE) && dsack_ok)
            wr_long_o <= data_i;
    end

endmodule

`default_nettype wire

/* logic/dma_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                          sclk_i,
    input  wire                          rst_n_i,
    input  wire sdmac_ctrl_pkg::dma_ctrl_t   ctrl_i,
    input  wire                          flush_req_i,
    input  wire                          push_half_i,
    input  wire sdmac_bus_pkg::periph_data_t wr_half_i,
    input  wire                          pop_half_i,
    input  wire                          push_long_i,
    input  wire sdmac_bus_pkg::host_data_t   wr_long_i,
    input  wire                          pop_long_i,
    output sdmac_bus_pkg::periph_data_t  rd_half_o,
    output sdmac_bus_pkg::host_data_t    rd_long_o,
    output sdmac_ctrl_pkg::fifo_stat_t   stat_o,
    output logic                         flush_done_o
);

    localparam int SLOT_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = SLOT_W + 2;   // Half bit, slot index, wrap bit

    sdmac_bus_pkg::host_data_t mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W-1:0]  level;             // Held halfwords
    logic [SLOT_W-1:0] wr_slot;
    logic [SLOT_W-1:0] rd_slot;
    logic              is_empty;
    logic              flush_pend_q;
    logic              pad;

    assign wr_slot  = wr_ptr_q[SLOT_W:1];
    assign rd_slot  = rd_ptr_q[SLOT_W:1];
    assign level    = wr_ptr_q - rd_ptr_q;
    assign is_empty = (level == '0);
    assign pad      = flush_req_i & wr_ptr_q[0] & ~push_half_i;   // Odd halfword waiting

    assign stat_o.empty    = is_empty;
    // Longword pushes need a whole free slot
    assign stat_o.full     = ctrl_i.dir ? (level >= PTR_W'(2 * FIFO_DEPTH - 1))
                                        : (level == PTR_W'(2 * FIFO_DEPTH));
    assign stat_o.long_rdy = (level >= PTR_W'(2));
    assign stat_o.half_rdy = ~is_empty;

    // First halfword is the upper half
    assign rd_long_o = mem_q[rd_slot];
    assign rd_half_o = rd_ptr_q[0] ? mem_q[rd_slot][15:0] : mem_q[rd_slot][31:16];

    always_ff @(posedge sclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            flush_pend_q <= 1'b0;
            flush_done_o <= 1'b0;
        end else if (!ctrl_i.dma_en) begin
            wr_ptr_q     <= '0;           // Disabled DMA discards the contents
            rd_ptr_q     <= '0;
            flush_pend_q <= 1'b0;
            flush_done_o <= 1'b0;
        end else begin
            if (push_half_i || pad)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            else if (push_long_i)
                wr_ptr_q <= wr_ptr_q + 2'd2;
            if (pop_half_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            else if (pop_long_i)
                rd_ptr_q <= rd_ptr_q + 2'd2;
            flush_done_o <= 1'b0;
            if (flush_req_i) begin
                flush_pend_q <= 1'b1;
            end else if (flush_pend_q && is_empty) begin
                flush_pend_q <= 1'b0;
                flush_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sclk_i) begin
        if (push_half_i) begin
            if (wr_ptr_q[0])
                mem_q[wr_slot][15:0] <= wr_half_i;
            else
                mem_q[wr_slot][31:16] <= wr_half_i;
        end else if (pad) begin
            mem_q[wr_slot][15:0] <= '0;
        end else if (push_long_i) begin
            mem_q[wr_slot] <= wr_long_i;
        end
    end

endmodule

`default_nettype wire

/* logic/resdmac.sv */
`timescale 1ns/1ps
`default_nettype none

module resdmac #(
    parameter int FIFO_DEPTH    = 4,
    parameter int STROBE_CYCLES = 2
) (
    input  wire                          sclk_i,
    input  wire                          rst_n_i,
    // Register port
    input  wire                          reg_sel_i,
    input  wire                          reg_we_i,
    input  wire sdmac_bus_pkg::reg_addr_t    reg_addr_i,
    input  wire sdmac_bus_pkg::host_data_t   reg_wdata_i,
    output sdmac_bus_pkg::host_data_t    reg_rdata_o,
    // Host bus master
    output logic                         br_o,
    input  wire                          bg_n_i,
    output logic                         own_o,
    output logic                         as_n_o,
    output logic                         ds_n_o,
    output logic                         rw_o,
    input  wire [1:0]                    dsack_n_i,
    input  wire                          berr_n_i,
    input  wire sdmac_bus_pkg::host_data_t   data_i,
    output sdmac_bus_pkg::host_data_t    data_o,
    // Peripheral port
    input  wire                          dreq_n_i,
    output logic                         dack_n_o,
    output logic                         ior_n_o,
    output logic                         iow_n_o,
    input  wire sdmac_bus_pkg::periph_data_t pd_i,
    output sdmac_bus_pkg::periph_data_t  pd_o,
    input  wire                          periph_int_i,
    output logic                         int_o
);

    sdmac_ctrl_pkg::dma_ctrl_t   ctrl;
    sdmac_ctrl_pkg::fifo_stat_t  stat;
    logic                        flush_req;
    logic                        flush_done;
    logic                        push_long;
    logic                        pop_long;
    sdmac_bus_pkg::host_data_t   wr_long;
    sdmac_bus_pkg::host_data_t   rd_long;
    logic                        push_half;
    logic                        pop_half;
    sdmac_bus_pkg::periph_data_t wr_half;
    sdmac_bus_pkg::periph_data_t rd_half;

    sdmac_regs u_regs (
        .sclk_i       (sclk_i),
        .rst_n_i      (rst_n_i),
        .reg_sel_i    (reg_sel_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .stat_i       (stat),
        .flush_done_i (flush_done),
        .periph_int_i (periph_int_i),
        .reg_rdata_o  (reg_rdata_o),
        .ctrl_o       (ctrl),
        .flush_req_o  (flush_req),
        .int_o        (int_o)
    );

    cpu_sm u_cpu_sm (
        .sclk_i      (sclk_i),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .stat_i      (stat),
        .bg_n_i      (bg_n_i),
        .dsack_n_i   (dsack_n_i),
        .berr_n_i    (berr_n_i),
        .data_i      (data_i),
        .rd_long_i   (rd_long),
        .br_o        (br_o),
        .own_o       (own_o),
        .as_n_o      (as_n_o),
        .ds_n_o      (ds_n_o),
        .rw_o        (rw_o),
        .data_o      (data_o),
        .push_long_o (push_long),
        .pop_long_o  (pop_long),
        .wr_long_o   (wr_long)
    );

    scsi_sm #(
        .STROBE_CYCLES (STROBE_CYCLES)
    ) u_scsi_sm (
        .sclk_i      (sclk_i),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .stat_i      (stat),
        .dreq_n_i    (dreq_n_i),
        .pd_i        (pd_i),
        .rd_half_i   (rd_half),
        .dack_n_o    (dack_n_o),
        .ior_n_o     (ior_n_o),
        .iow_n_o     (iow_n_o),
        .pd_o        (pd_o),
        .push_half_o (push_half),
        .pop_half_o  (pop_half),
        .wr_half_o   (wr_half)
    );

    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .sclk_i       (sclk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .flush_req_i  (flush_req),
        .push_half_i  (push_half),
        .wr_half_i    (wr_half),
        .pop_half_i   (pop_half),
        .push_long_i  (push_long),
        .wr_long_i    (wr_long),
        .pop_long_i   (pop_long),
        .rd_half_o    (rd_half),
        .rd_long_o    (rd_long),
        .stat_o       (stat),
        .flush_done_o (flush_done)
    );

endmodule

`default_nettype wire

/* logic/scsi_sm.sv */
`timescale 1ns/1ps
`default_nettype none

module scsi_sm #(
    parameter int STROBE_CYCLES = 2
) (
    input  wire                          sclk_i,
    input  wire                          rst_n_i,
    input  wire sdmac_ctrl_pkg::dma_ctrl_t   ctrl_i,
    input  wire sdmac_ctrl_pkg::fifo_stat_t  stat_i,
    input  wire                          dreq_n_i,
    input  wire sdmac_bus_pkg::periph_data_t pd_i,
    input  wire sdmac_bus_pkg::periph_data_t rd_half_i,
    output logic                         dack_n_o,
    output logic                         ior_n_o,
    output logic                         iow_n_o,
    output sdmac_bus_pkg::periph_data_t  pd_o,
    output logic                         push_half_o,
    output logic                         pop_half_o,
    output sdmac_bus_pkg::periph_data_t  wr_half_o
);

    localparam int CNT_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

    sdmac_ctrl_pkg::scsi_state_t state_q;
    logic [CNT_W-1:0] cnt_q;      // Strobe width
    logic can_start;
    logic last_strobe;

    // Full FIFO holds off reads, no halfword holds off writes
    assign can_start = ctrl_i.dma_en & ~dreq_n_i &
                       (ctrl_i.dir ? stat_i.half_rdy : ~stat_i.full);
    assign last_strobe = (state_q == sdmac_ctrl_pkg::SCSI_STROBE) &&
                         (cnt_q == CNT_W'(STROBE_CYCLES - 1));

    // Active strobe tells the direction of the cycle in flight
    assign push_half_o = last_strobe & ~ior_n_o;
    assign pop_half_o  = last_strobe & ~iow_n_o;
    assign wr_half_o   = pd_i;

    always_ff @(posedge sclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= sdmac_ctrl_pkg::SCSI_IDLE;
            cnt_q    <= '0;
            dack_n_o <= 1'b1;
            ior_n_o  <= 1'b1;
            iow_n_o  <= 1'b1;
        end else begin
            case (state_q)
                sdmac_ctrl_pkg::SCSI_IDLE: begin
                    if (can_start) begin
                        dack_n_o <= 1'b0;
                        ior_n_o  <= ctrl_i.dir;
                        iow_n_o  <= ~ctrl_i.dir;
                        cnt_q    <= '0;
                        state_q  <= sdmac_ctrl_pkg::SCSI_STROBE;
                    end
                end
                sdmac_ctrl_pkg::SCSI_STROBE: begin
                    if (last_strobe) begin
                        dack_n_o <= 1'b1;
                        ior_n_o  <= 1'b1;
                        iow_n_o  <= 1'b1;
                        state_q  <= sdmac_ctrl_pkg::SCSI_HOLD;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                sdmac_ctrl_pkg::SCSI_HOLD: state_q <= sdmac_ctrl_pkg::SCSI_IDLE;  // Recovery
                default: state_q <= sdmac_ctrl_pkg::SCSI_IDLE;
            endcase
        end
    end

    // Write data stays on the port for the whole strobe
    always_ff @(posedge sclk_i) begin
        if ((state_q == sdmac_ctrl_pkg::SCSI_IDLE) && can_start)
            pd_o <= rd_half_i;
    end

endmodule

`default_nettype wire

/* logic/sdmac_bus_pkg.sv */
`default_nettype none

package sdmac_bus_pkg;

    // Bus widths
    localparam int HOST_DW   = 32;    // 68030 longword
    localparam int PERIPH_DW = 16;    // WD33C93 data port
    localparam int REG_AW    = 5;     // Host address bits 6 to 2

    typedef logic [HOST_DW-1:0]   host_data_t;
    typedef logic [PERIPH_DW-1:0] periph_data_t;
    typedef logic [REG_AW-1:0]    reg_addr_t;

endpackage

`default_nettype wire

/* logic/sdmac_ctrl_pkg.sv */
`default_nettype none

package sdmac_ctrl_pkg;

    // Register offsets, already shifted right by two
    localparam sdmac_bus_pkg::reg_addr_t ADDR_CNTR  = 5'h02;  // 0x08
    localparam sdmac_bus_pkg::reg_addr_t ADDR_FLUSH = 5'h05;  // 0x14
    localparam sdmac_bus_pkg::reg_addr_t ADDR_ISTR  = 5'h07;  // 0x1C

    typedef struct packed {
        logic dir;        // 1 memory to peripheral
        logic dma_en;
        logic int_en;
    } dma_ctrl_t;

    typedef struct packed {
        logic empty;
        logic full;       // No room for another halfword
        logic long_rdy;   // Complete longword at the head
        logic half_rdy;
    } fifo_stat_t;

    typedef enum logic [2:0] {
        CPU_IDLE,
        CPU_REQ,
        CPU_OWN,
        CPU_CYCLE,
        CPU_RELEASE
    } cpu_state_t;

    typedef enum logic [1:0] {
        SCSI_IDLE,
        SCSI_STROBE,
        SCSI_HOLD
    } scsi_state_t;

endpackage

`default_nettype wire

/* logic/sdmac_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sdmac_regs (
    input  wire                        sclk_i,
    input  wire                        rst_n_i,
    input  wire                        reg_sel_i,
    input  wire                        reg_we_i,
    input  wire sdmac_bus_pkg::reg_addr_t  reg_addr_i,
    input  wire sdmac_bus_pkg::host_data_t reg_wdata_i,
    input  wire sdmac_ctrl_pkg::fifo_stat_t stat_i,
    input  wire                        flush_done_i,
    input  wire                        periph_int_i,
    output sdmac_bus_pkg::host_data_t  reg_rdata_o,
    output sdmac_ctrl_pkg::dma_ctrl_t  ctrl_o,
    output logic                       flush_req_o,
    output logic                       int_o
);

    logic wr_en;
    logic rd_en;
    logic flush_done_q;   // Sticky until status is read

    assign wr_en = reg_sel_i & reg_we_i;
    assign rd_en = reg_sel_i & ~reg_we_i;

    always_ff @(posedge sclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_o       <= '0;
            flush_req_o  <= 1'b0;
            flush_done_q <= 1'b0;
        end else begin
            flush_req_o <= wr_en && (reg_addr_i == sdmac_ctrl_pkg::ADDR_FLUSH);
            if (wr_en && (reg_addr_i == sdmac_ctrl_pkg::ADDR_CNTR))
                ctrl_o <= sdmac_ctrl_pkg::dma_ctrl_t'(reg_wdata_i[2:0]);
            // A new completion wins over a clearing read
            if (flush_done_i)
                flush_done_q <= 1'b1;
            else if (rd_en && (reg_addr_i == sdmac_ctrl_pkg::ADDR_ISTR))
                flush_done_q <= 1'b0;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (rd_en) begin
            case (reg_addr_i)
                sdmac_ctrl_pkg::ADDR_CNTR: reg_rdata_o <= sdmac_bus_pkg::host_data_t'(ctrl_o);
                sdmac_ctrl_pkg::ADDR_ISTR:
                    reg_rdata_o <= sdmac_bus_pkg::host_data_t'({periph_int_i,
                                                               flush_done_q, stat_i});
                default: reg_rdata_o <= '0;
            endcase
        end
    end

    assign int_o = ctrl_o.int_en & (periph_int_i | flush_done_q);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the resdmac testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_resdmac -f verilog.f -o Vtb_resdmac

./obj_dir/Vtb_resdmac 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verilog.f */
logic/sdmac_bus_pkg.sv
logic/sdmac_ctrl_pkg.sv
logic/sdmac_regs.sv
logic/cpu_sm.sv
logic/scsi_sm.sv
logic/dma_fifo.sv
logic/resdmac.sv
dv/resdmac_checker.sv
dv/tb_resdmac.sv
